// File: cpu_types_pkg.sv
// word and register types, opcode, funct and alu-op enums, datapath select enums
`default_nettype none

package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // primary opcode in instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // funct codes of the rtype subset
  typedef enum logic [5:0] {
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluop_t;

  typedef enum logic {SEL_REG_DATA, SEL_IMM16} alu_src_t;
  typedef enum logic {SEL_RD, SEL_RT} reg_dest_t;
  typedef enum logic {SEL_RESULT, SEL_DLOAD} mem_to_reg_t;

  typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extend_t;

  // next pc choice, branch beats jump
  typedef enum logic [1:0] {
    SEL_LOAD_NXT_INSTR,
    SEL_LOAD_JMP_ADDR,
    SEL_LOAD_BR_ADDR
  } pc_src_t;

  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

endpackage

`default_nettype wire

// File: datapath_cache_if.sv
// datapath to memory request/hit interface with dp and cache modports
`default_nettype none

interface datapath_cache_if;
  import cpu_types_pkg::*;

  // instruction side
  logic  imemREN;
  word_t imemaddr;
  logic  ihit;
  word_t imemload;

  // data side, request held until dhit
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemaddr;
  word_t dmemstore;
  logic  dhit;
  word_t dmemload;

  logic  halt;

  modport dp (
    input  ihit, imemload, dhit, dmemload,
    output imemREN, imemaddr, dmemREN, dmemWEN, dmemaddr, dmemstore, halt
  );

  modport cache (
    input  imemREN, imemaddr, dmemREN, dmemWEN, dmemaddr, dmemstore, halt,
    output ihit, imemload, dhit, dmemload
  );

endinterface

`default_nettype wire

// File: register_file.sv
// 32x32 register file, zero register and write-before-read bypass
`default_nettype none

module register_file (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  // register 0 has no storage
  word_t regs [31:1];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // same-cycle write shows up on the read ports
  always_comb begin
    if (rsel1 == '0)
      rdat1 = '0;
    else if (wen && wsel == rsel1)
      rdat1 = wdat;
    else
      rdat1 = regs[rsel1];

    if (rsel2 == '0)
      rdat2 = '0;
    else if (wen && wsel == rsel2)
      rdat2 = wdat;
    else
      rdat2 = regs[rsel2];
  end

endmodule

`default_nettype wire

// File: alu.sv
// alu with add, sub, and, or, signed slt, upper pass and zero flag
`default_nettype none

module alu (
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  input  cpu_types_pkg::aluop_t alu_op,
  output cpu_types_pkg::word_t  result,
  output logic                  zero
);
  import cpu_types_pkg::*;

  always_comb begin
    case (alu_op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      ALU_SLT: begin
        result = ($signed(port_a) < $signed(port_b)) ? 32'd1 : 32'd0;
      end
      // immediate already shifted up by the extender
      ALU_LUI: result = port_b;
      default: result = '0;
    endcase
  end

  // drives beq/bne in ex
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: control_unit.sv
// instruction decoder for alu op, source selects, enables and halt
`default_nettype none

module control_unit (
  input  cpu_types_pkg::word_t       instr,
  output cpu_types_pkg::aluop_t      alu_op,
  output cpu_types_pkg::alu_src_t    alu_src,
  output cpu_types_pkg::reg_dest_t   reg_dest,
  output cpu_types_pkg::mem_to_reg_t mem_to_reg,
  output cpu_types_pkg::extend_t     extend,
  output logic                       wen,
  output logic                       dren,
  output logic                       dwen,
  output logic                       branch,
  output logic                       branch_ne,
  output logic                       jump,
  output logic                       halt
);
  import cpu_types_pkg::*;

  opcode_t op;
  funct_t  fn;

  assign op = opcode_t'(instr[31:26]);
  assign fn = funct_t'(instr[5:0]);

  always_comb begin
    // no-op unless a known code overrides
    alu_op     = ALU_ADD;
    alu_src    = SEL_REG_DATA;
    reg_dest   = SEL_RD;
    mem_to_reg = SEL_RESULT;
    extend     = EXT_SIGN;
    wen        = 1'b0;
    dren       = 1'b0;
    dwen       = 1'b0;
    branch     = 1'b0;
    branch_ne  = 1'b0;
    jump       = 1'b0;
    halt       = 1'b0;

    case (op)
      RTYPE: begin
        wen = 1'b1;
        case (fn)
          ADDU:    alu_op = ALU_ADD;
          SUBU:    alu_op = ALU_SUB;
          AND:     alu_op = ALU_AND;
          OR:      alu_op = ALU_OR;
          SLT:     alu_op = ALU_SLT;
          default: wen = 1'b0;
        endcase
      end
      ADDIU: begin
        alu_src  = SEL_IMM16;
        reg_dest = SEL_RT;
        wen      = 1'b1;
      end
      ORI: begin
        alu_op   = ALU_OR;
        alu_src  = SEL_IMM16;
        reg_dest = SEL_RT;
        extend   = EXT_ZERO;
        wen      = 1'b1;
      end
      LUI: begin
        alu_op   = ALU_LUI;
        alu_src  = SEL_IMM16;
        reg_dest = SEL_RT;
        extend   = EXT_UPPER;
        wen      = 1'b1;
      end
      LW: begin
        alu_src    = SEL_IMM16;
        reg_dest   = SEL_RT;
        mem_to_reg = SEL_DLOAD;
        dren       = 1'b1;
        wen        = 1'b1;
      end
      SW: begin
        alu_src = SEL_IMM16;
        dwen    = 1'b1;
      end
      BEQ: begin
        alu_op = ALU_SUB;
        branch = 1'b1;
      end
      BNE: begin
        alu_op    = ALU_SUB;
        branch    = 1'b1;
        branch_ne = 1'b1;
      end
      J:       jump = 1'b1;
      HALT:    halt = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: forward_unit.sv
// alu operand forwarding from ex/mem and mem/wb destinations
`default_nettype none

module forward_unit (
  input  cpu_types_pkg::regbits_t rs,
  input  cpu_types_pkg::regbits_t rt,
  input  logic                    wen_mem,
  input  logic                    wen_wb,
  input  cpu_types_pkg::regbits_t dest_mem,
  input  cpu_types_pkg::regbits_t dest_wb,
  output cpu_types_pkg::fwd_sel_t porta_sel,
  output cpu_types_pkg::fwd_sel_t portb_sel
);
  import cpu_types_pkg::*;

  // younger producer in ex/mem wins, $0 never forwards
  function automatic fwd_sel_t pick(input regbits_t src);
    fwd_sel_t sel;
    sel = FWD_NONE;
    if (src != '0) begin
      if (wen_mem && dest_mem == src)
        sel = FWD_MEM;
      else if (wen_wb && dest_wb == src)
        sel = FWD_WB;
    end
    return sel;
  endfunction

  assign porta_sel = pick(rs);
  assign portb_sel = pick(rt);

endmodule

`default_nettype wire

// File: hazard_unit.sv
// stage enables, flushes and next-pc select for memory, load-use and control hazards
`default_nettype none

module hazard_unit (
  input  logic                    ihit,
  input  logic                    dhit,
  input  logic                    dmem_busy,
  input  logic                    load_ex,
  input  cpu_types_pkg::regbits_t dest_ex,
  input  cpu_types_pkg::regbits_t rs_id,
  input  cpu_types_pkg::regbits_t rt_id,
  input  logic                    branch_taken,
  input  logic                    jump_id,
  output logic                    enable_pc,
  output logic                    enable_if_id,
  output logic                    enable_id_ex,
  output logic                    enable_ex_mem,
  output logic                    enable_mem_wb,
  output logic                    flush_if_id,
  output logic                    flush_id_ex,
  output logic                    flush_ex_mem,
  output cpu_types_pkg::pc_src_t  pc_src
);
  import cpu_types_pkg::*;

  logic mem_stall;
  logic br_wait;
  logic load_use;
  logic back_en;

  assign mem_stall = dmem_busy & ~dhit;
  // redirect waits for the open fetch to finish
  assign br_wait   = branch_taken & ~ihit;
  assign load_use  = load_ex && dest_ex != '0 && (dest_ex == rs_id || dest_ex == rt_id);
  assign back_en   = ~mem_stall & ~br_wait;

  assign enable_id_ex  = back_en;
  assign enable_ex_mem = back_en;
  assign enable_mem_wb = back_en;

  // front end moves only on a completed fetch
  assign enable_pc    = ihit & back_en & (~load_use | branch_taken);
  assign enable_if_id = enable_pc;

  assign flush_if_id  = branch_taken | jump_id;
  assign flush_id_ex  = branch_taken | load_use | ~ihit;
  assign flush_ex_mem = branch_taken;

  always_comb begin
    if (branch_taken)
      pc_src = SEL_LOAD_BR_ADDR;
    else if (jump_id)
      pc_src = SEL_LOAD_JMP_ADDR;
    else
      pc_src = SEL_LOAD_NXT_INSTR;
  end

endmodule

`default_nettype wire

// File: datapath.sv
// pipelined datapath with pc, stage registers, muxes, extender, adders and hazard glue
`default_nettype none

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input logic          CLK,
  input logic          rst_n,
  datapath_cache_if.dp dpif
);
  import cpu_types_pkg::*;

  typedef struct packed {
    word_t instr;
    word_t npc;
  } if_id_t;

  typedef struct packed {
    aluop_t      alu_op;
    alu_src_t    alu_src;
    mem_to_reg_t mem_to_reg;
    logic        wen;
    logic        dren;
    logic        dwen;
    logic        branch;
    logic        branch_ne;
    logic        halt;
    regbits_t    rs;
    regbits_t    rt;
    regbits_t    dest;
    word_t       rdat1;
    word_t       rdat2;
    word_t       imm_ext;
    word_t       npc;
  } id_ex_t;

  typedef struct packed {
    mem_to_reg_t mem_to_reg;
    logic        wen;
    logic        dren;
    logic        dwen;
    logic        halt;
    logic        br_taken;
    regbits_t    dest;
    word_t       result;
    word_t       store;
    word_t       br_addr;
  } ex_mem_t;

  typedef struct packed {
    mem_to_reg_t mem_to_reg;
    logic        wen;
    logic        halt;
    regbits_t    dest;
    word_t       result;
    word_t       dload;
  } mem_wb_t;

  word_t   pc, npc, next_pc, jmp_addr;
  if_id_t  if_id_q;
  id_ex_t  id_ex_q, id_ex_d;
  ex_mem_t ex_mem_q, ex_mem_d;
  mem_wb_t mem_wb_q, mem_wb_d;

  aluop_t      cu_alu_op;
  alu_src_t    cu_alu_src;
  reg_dest_t   cu_reg_dest;
  mem_to_reg_t cu_mem_to_reg;
  extend_t     cu_extend;
  logic        cu_wen, cu_dren, cu_dwen;
  logic        cu_branch, cu_branch_ne, cu_jump, cu_halt;

  word_t    rdat1, rdat2, imm_ext, wdat;
  regbits_t dest_id;
  fwd_sel_t porta_sel, portb_sel;
  word_t    port_a, rt_fwd, port_b, alu_result;
  logic     alu_zero;

  logic    en_pc, en_if_id, en_id_ex, en_ex_mem, en_mem_wb;
  logic    flush_if_id, flush_id_ex, flush_ex_mem;
  pc_src_t pc_src;
  logic    run;

  // halt in mem/wb freezes the whole pipe
  assign run = ~mem_wb_q.halt;

  // fetch
  assign npc = pc + 32'd4;

  always_comb begin
    case (pc_src)
      SEL_LOAD_JMP_ADDR: next_pc = jmp_addr;
      SEL_LOAD_BR_ADDR:  next_pc = ex_mem_q.br_addr;
      default:           next_pc = npc;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      pc <= PC_INIT;
    else if (en_pc && run)
      pc <= next_pc;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      if_id_q <= '0;
    else if (en_if_id && run)
      if_id_q <= flush_if_id ? '0 : {dpif.imemload, npc};
  end

  // decode
  control_unit cu (
    .instr      (if_id_q.instr),
    .alu_op     (cu_alu_op),
    .alu_src    (cu_alu_src),
    .reg_dest   (cu_reg_dest),
    .mem_to_reg (cu_mem_to_reg),
    .extend     (cu_extend),
    .wen        (cu_wen),
    .dren       (cu_dren),
    .dwen       (cu_dwen),
    .branch     (cu_branch),
    .branch_ne  (cu_branch_ne),
    .jump       (cu_jump),
    .halt       (cu_halt)
  );

  register_file rf (
    .CLK   (CLK),
    .rst_n (rst_n),
    .wen   (mem_wb_q.wen),
    .wsel  (mem_wb_q.dest),
    .wdat  (wdat),
    .rsel1 (if_id_q.instr[25:21]),
    .rsel2 (if_id_q.instr[20:16]),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  always_comb begin
    case (cu_extend)
      EXT_ZERO:  imm_ext = {16'h0000, if_id_q.instr[15:0]};
      EXT_UPPER: imm_ext = {if_id_q.instr[15:0], 16'h0000};
      default:   imm_ext = {{16{if_id_q.instr[15]}}, if_id_q.instr[15:0]};
    endcase
  end

  assign dest_id  = (cu_reg_dest == SEL_RT) ? if_id_q.instr[20:16] : if_id_q.instr[15:11];
  assign jmp_addr = {if_id_q.npc[31:28], if_id_q.instr[25:0], 2'b00};

  always_comb begin
    id_ex_d.alu_op     = cu_alu_op;
    id_ex_d.alu_src    = cu_alu_src;
    id_ex_d.mem_to_reg = cu_mem_to_reg;
    id_ex_d.wen        = cu_wen;
    id_ex_d.dren       = cu_dren;
    id_ex_d.dwen       = cu_dwen;
    id_ex_d.branch     = cu_branch;
    id_ex_d.branch_ne  = cu_branch_ne;
    id_ex_d.halt       = cu_halt;
    id_ex_d.rs         = if_id_q.instr[25:21];
    id_ex_d.rt         = if_id_q.instr[20:16];
    id_ex_d.dest       = dest_id;
    id_ex_d.rdat1      = rdat1;
    id_ex_d.rdat2      = rdat2;
    id_ex_d.imm_ext    = imm_ext;
    id_ex_d.npc        = if_id_q.npc;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      id_ex_q <= '0;
    else if (en_id_ex && run)
      id_ex_q <= flush_id_ex ? '0 : id_ex_d;
  end

  // execute
  forward_unit fu (
    .rs        (id_ex_q.rs),
    .rt        (id_ex_q.rt),
    .wen_mem   (ex_mem_q.wen),
    .wen_wb    (mem_wb_q.wen),
    .dest_mem  (ex_mem_q.dest),
    .dest_wb   (mem_wb_q.dest),
    .porta_sel (porta_sel),
    .portb_sel (portb_sel)
  );

  always_comb begin
    case (porta_sel)
      FWD_MEM: port_a = ex_mem_q.result;
      FWD_WB:  port_a = wdat;
      default: port_a = id_ex_q.rdat1;
    endcase
  end

  // forwarded rt also feeds the store data
  always_comb begin
    case (portb_sel)
      FWD_MEM: rt_fwd = ex_mem_q.result;
      FWD_WB:  rt_fwd = wdat;
      default: rt_fwd = id_ex_q.rdat2;
    endcase
  end

  assign port_b = (id_ex_q.alu_src == SEL_IMM16) ? id_ex_q.imm_ext : rt_fwd;

  alu alu_i (
    .port_a (port_a),
    .port_b (port_b),
    .alu_op (id_ex_q.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  always_comb begin
    ex_mem_d.mem_to_reg = id_ex_q.mem_to_reg;
    ex_mem_d.wen        = id_ex_q.wen;
    ex_mem_d.dren       = id_ex_q.dren;
    ex_mem_d.dwen       = id_ex_q.dwen;
    ex_mem_d.halt       = id_ex_q.halt;
    // bne inverts the zero test
    ex_mem_d.br_taken   = id_ex_q.branch & (alu_zero ^ id_ex_q.branch_ne);
    ex_mem_d.dest       = id_ex_q.dest;
    ex_mem_d.result     = alu_result;
    ex_mem_d.store      = rt_fwd;
    ex_mem_d.br_addr    = id_ex_q.npc + {id_ex_q.imm_ext[29:0], 2'b00};
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      ex_mem_q <= '0;
    else if (en_ex_mem && run)
      ex_mem_q <= flush_ex_mem ? '0 : ex_mem_d;
  end

  // memory
  assign dpif.imemREN   = run;
  assign dpif.imemaddr  = pc;
  assign dpif.dmemREN   = ex_mem_q.dren & run;
  assign dpif.dmemWEN   = ex_mem_q.dwen & run;
  assign dpif.dmemaddr  = ex_mem_q.result;
  assign dpif.dmemstore = ex_mem_q.store;
  assign dpif.halt      = mem_wb_q.halt;

  always_comb begin
    mem_wb_d.mem_to_reg = ex_mem_q.mem_to_reg;
    mem_wb_d.wen        = ex_mem_q.wen;
    mem_wb_d.halt       = ex_mem_q.halt;
    mem_wb_d.dest       = ex_mem_q.dest;
    mem_wb_d.result     = ex_mem_q.result;
    mem_wb_d.dload      = dpif.dmemload;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n)
      mem_wb_q <= '0;
    else if (en_mem_wb && run)
      mem_wb_q <= mem_wb_d;
  end

  // write back
  assign wdat = (mem_wb_q.mem_to_reg == SEL_DLOAD) ? mem_wb_q.dload : mem_wb_q.result;

  hazard_unit hu (
    .ihit          (dpif.ihit),
    .dhit          (dpif.dhit),
    .dmem_busy     (ex_mem_q.dren | ex_mem_q.dwen),
    .load_ex       (id_ex_q.dren),
    .dest_ex       (id_ex_q.dest),
    .rs_id         (if_id_q.instr[25:21]),
    .rt_id         (if_id_q.instr[20:16]),
    .branch_taken  (ex_mem_q.br_taken),
    .jump_id       (cu_jump),
    .enable_pc     (en_pc),
    .enable_if_id  (en_if_id),
    .enable_id_ex  (en_id_ex),
    .enable_ex_mem (en_ex_mem),
    .enable_mem_wb (en_mem_wb),
    .flush_if_id   (flush_if_id),
    .flush_id_ex   (flush_id_ex),
    .flush_ex_mem  (flush_ex_mem),
    .pc_src        (pc_src)
  );

endmodule

`default_nettype wire

// File: pipeline_cpu.sv
// processor top level, datapath with plain instruction and data memory ports
`default_nettype none

module pipeline_cpu #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  output logic                 imemREN,
  output cpu_types_pkg::word_t imemaddr,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imemload,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 halt
);

  datapath_cache_if dpif ();

  datapath #(
    .PC_INIT (PC_INIT)
  ) dp (
    .CLK   (CLK),
    .rst_n (rst_n),
    .dpif  (dpif.dp)
  );

  // memory side of the interface
  assign dpif.ihit     = ihit;
  assign dpif.imemload = imemload;
  assign dpif.dhit     = dhit;
  assign dpif.dmemload = dmemload;

  assign imemREN   = dpif.imemREN;
  assign imemaddr  = dpif.imemaddr;
  assign dmemREN   = dpif.dmemREN;
  assign dmemWEN   = dpif.dmemWEN;
  assign dmemaddr  = dpif.dmemaddr;
  assign dmemstore = dpif.dmemstore;
  assign halt      = dpif.halt;

endmodule

`default_nettype wire

// File: pipeline_cpu_tb.sv
// testbench for pipeline_cpu with a wait-state memory model and directed program tests
`default_nettype none

module pipeline_cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_types_pkg::*;

  localparam word_t pc_init    = 32'h0000_0080;
  localparam word_t data_base  = 32'h0000_0300;
  localparam word_t load_addr  = 32'h0000_0200;
  // eight runs of 16 reset cycles, 10 halt cycles and under 150 program cycles each
  localparam int    max_cycles = 4000;

  // mips encodings
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] fn_addu  = 6'h21;
  localparam logic [5:0] fn_subu  = 6'h23;
  localparam logic [5:0] fn_and   = 6'h24;
  localparam logic [5:0] fn_or    = 6'h25;
  localparam logic [5:0] fn_slt   = 6'h2a;
  localparam word_t      halt_instr = 32'hfc00_0000;

  logic  CLK;
  logic  rst_n;
  logic  imemREN;
  word_t imemaddr;
  logic  ihit;
  word_t imemload;
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemaddr;
  word_t dmemstore;
  logic  dhit;
  word_t dmemload;
  logic  halt;

  word_t  mem [0:255];
  int     errors;
  int     cycle_count;
  int     load_ptr;
  integer seed;
  bit     random_waits;

  word_t exp_addr [$];
  word_t exp_data [$];
  word_t st_addr [$];
  word_t st_data [$];
  int    st_cycle [$];

  // memory model state
  int unsigned iwait;
  int unsigned dwait;
  logic        live;
  logic        dreq;
  logic        dreq_prev;
  logic        pend_valid;
  logic        pend_wen;
  word_t       pend_addr;
  word_t       pend_data;

  pipeline_cpu #(
    .PC_INIT (pc_init)
  ) dut (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .imemREN   (imemREN),
    .imemaddr  (imemaddr),
    .ihit      (ihit),
    .imemload  (imemload),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dhit      (dhit),
    .dmemload  (dmemload),
    .halt      (halt)
  );

  always #4 CLK = ~CLK;

  function automatic int unsigned draw_wait();
    if (!random_waits)
      return 0;
    return $unsigned($random(seed)) % 4;
  endfunction

  function automatic word_t rtype(input logic [5:0] fn, input int rs, input int rt,
                                  input int rd);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'h00, fn};
  endfunction

  function automatic word_t itype(input logic [5:0] op, input int rs, input int rt,
                                  input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic word_t jword(input word_t target);
    return {op_j, target[27:2]};
  endfunction

  // value of a 16-bit two's complement immediate as a word
  function automatic word_t sext(input int imm);
    word_t low;
    low = imm & 32'h0000_ffff;
    if (low >= 32'h0000_8000)
      return low - 32'h0001_0000;
    return low;
  endfunction

  // signed order from the sign bits, unsigned order within one sign
  function automatic word_t slt_ref(input word_t a, input word_t b);
    if (a[31] != b[31])
      return {31'd0, a[31]};
    return (a < b) ? 32'd1 : 32'd0;
  endfunction

  // hits on both ports driven 1 ns after the edge
  always @(posedge CLK) begin
    live = rst_n;
    #1;
    if (!live) begin
      iwait     = 0;
      dwait     = 0;
      dreq_prev = 1'b0;
      ihit      = 1'b0;
      dhit      = 1'b0;
      imemload  = '0;
      dmemload  = '0;
    end else begin
      if (ihit)
        iwait = draw_wait();
      else if (iwait != 0)
        iwait = iwait - 1;
      ihit     = imemREN && (iwait == 0);
      imemload = mem[imemaddr[9:2]];

      dreq = dmemREN || dmemWEN;
      // a fresh request draws its own latency
      if (dreq && (!dreq_prev || dhit))
        dwait = draw_wait();
      else if (dwait != 0)
        dwait = dwait - 1;
      dhit      = dreq && (dwait == 0);
      dreq_prev = dreq;
      dmemload  = dmemREN ? mem[dmemaddr[9:2]] : '0;
    end
  end

  // store log and request stability checks at the falling edge
  always @(negedge CLK) begin
    if (!rst_n) begin
      pend_valid = 1'b0;
    end else if (dmemREN || dmemWEN) begin
      assert (!(dmemREN && dmemWEN))
        else note_failure("dmemREN and dmemWEN both high");
      if (pend_valid) begin
        assert (dmemaddr == pend_addr)
          else report_mismatch("dmemaddr before dhit", pend_addr, dmemaddr);
        assert (dmemWEN == pend_wen)
          else report_mismatch("dmemWEN before dhit", pend_wen, dmemWEN);
        if (pend_wen) begin
          assert (dmemstore == pend_data)
            else report_mismatch("dmemstore before dhit", pend_data, dmemstore);
        end
      end
      if (dhit) begin
        pend_valid = 1'b0;
        if (dmemWEN) begin
          mem[dmemaddr[9:2]] = dmemstore;
          st_addr.push_back(dmemaddr);
          st_data.push_back(dmemstore);
          st_cycle.push_back(cycle_count);
        end
      end else begin
        pend_valid = 1'b1;
        pend_wen   = dmemWEN;
        pend_addr  = dmemaddr;
        pend_data  = dmemstore;
      end
    end else begin
      assert (!pend_valid)
        else note_failure("data request dropped before its dhit");
      pend_valid = 1'b0;
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      errors++;
      $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("errors: %0d", errors);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    errors++;
    $display("FAIL %s: expected %h, got %h", name, expected, actual);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  // fill words hold their index under the no-op opcode 3e
  task automatic begin_program();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hf800_0000 | i;
    end
    load_ptr = pc_init[9:2];
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic emit(input word_t instr);
    mem[load_ptr] = instr;
    load_ptr++;
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic compare_stores();
    int n;
    assert (st_addr.size() == exp_addr.size())
      else note_failure($sformatf("wrong number of stores: expected %0d, saw %0d",
                                  exp_addr.size(), st_addr.size()));
    n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      assert (st_addr[i] == exp_addr[i])
        else report_mismatch($sformatf("store %0d dmemaddr", i), exp_addr[i], st_addr[i]);
      assert (st_data[i] == exp_data[i])
        else report_mismatch($sformatf("dmemstore at %h", exp_addr[i]), exp_data[i],
                             st_data[i]);
    end
  endtask

  // reset and run to halt before checking the halted state and the stores
  task automatic run_program(output int first_store);
    int start;
    int stores_at_halt;
    st_addr.delete();
    st_data.delete();
    st_cycle.delete();
    @(posedge CLK);
    #1 rst_n = 1'b0;
    repeat (15) @(posedge CLK);
    @(negedge CLK);
    assert (dmemREN == 1'b0) else report_mismatch("dmemREN in reset", 0, dmemREN);
    assert (dmemWEN == 1'b0) else report_mismatch("dmemWEN in reset", 0, dmemWEN);
    assert (halt == 1'b0) else report_mismatch("halt in reset", 0, halt);
    assert (imemaddr == pc_init) else report_mismatch("imemaddr in reset", pc_init, imemaddr);
    @(posedge CLK);
    #1 rst_n = 1'b1;
    start = cycle_count;
    while (!halt) @(negedge CLK);
    stores_at_halt = st_addr.size();
    repeat (10) begin
      @(negedge CLK);
      assert (halt == 1'b1) else report_mismatch("halt after halt", 1, halt);
      assert (imemREN == 1'b0) else report_mismatch("imemREN after halt", 0, imemREN);
    end
    assert (st_addr.size() == stores_at_halt)
      else note_failure("store completed after halt");
    compare_stores();
    first_store = (st_cycle.size() > 0) ? st_cycle[0] - start : -1;
  endtask

  task automatic test_alu_chain();
    word_t v [1:11];
    int    first;
    begin_program();
    emit(itype(op_lui, 0, 1, 'h1234));
    emit(itype(op_ori, 1, 1, 'h5678));
    emit(itype(op_addiu, 1, 2, -16));
    emit(rtype(fn_addu, 2, 1, 3));
    emit(rtype(fn_subu, 3, 2, 4));
    emit(rtype(fn_and, 4, 3, 5));
    emit(rtype(fn_or, 5, 2, 6));
    emit(rtype(fn_slt, 6, 1, 7));
    emit(itype(op_addiu, 0, 8, 'hffff));
    emit(rtype(fn_slt, 7, 8, 9));
    emit(itype(op_ori, 0, 10, 'h8000));
    emit(itype(op_addiu, 0, 11, 'h8000));
    for (int k = 1; k <= 11; k++) begin
      emit(itype(op_sw, 0, k, data_base + 4 * (k - 1)));
    end
    emit(halt_instr);

    // sequential results
    v[1]  = (32'h1234 << 16) | 32'h5678;
    v[2]  = v[1] + sext(-16);
    v[3]  = v[2] + v[1];
    v[4]  = v[3] - v[2];
    v[5]  = v[4] & v[3];
    v[6]  = v[5] | v[2];
    v[7]  = slt_ref(v[6], v[1]);
    v[8]  = sext('hffff);
    v[9]  = slt_ref(v[7], v[8]);
    v[10] = 32'h0000_8000;
    v[11] = sext('h8000);
    for (int k = 1; k <= 11; k++) begin
      expect_store(data_base + 4 * (k - 1), v[k]);
    end
    run_program(first);
  endtask

  // loaded value used at once or one slot later
  task automatic load_use_program(input bit dependent);
    word_t ld_val;
    ld_val = 32'h4000_1234;
    begin_program();
    mem[load_addr[9:2]] = ld_val;
    emit(itype(op_lw, 0, 2, load_addr));
    if (dependent) begin
      emit(rtype(fn_addu, 2, 2, 3));
      emit(itype(op_ori, 0, 5, 'h55));
    end else begin
      emit(itype(op_ori, 0, 5, 'h55));
      emit(rtype(fn_addu, 2, 2, 3));
    end
    emit(itype(op_sw, 0, 3, data_base));
    emit(itype(op_sw, 0, 5, data_base + 4));
    emit(halt_instr);
    expect_store(data_base, ld_val + ld_val);
    expect_store(data_base + 4, 32'h0000_0055);
  endtask

  task automatic test_load_use();
    int dep_cycle;
    int indep_cycle;
    load_use_program(1'b1);
    run_program(dep_cycle);
    load_use_program(1'b0);
    run_program(indep_cycle);
    // one bubble only counts with fixed latency
    if (!random_waits) begin
      assert (dep_cycle == indep_cycle + 1)
        else report_mismatch("load-use first store cycle", indep_cycle + 1, dep_cycle);
    end
  endtask

  task automatic test_branches();
    int first;
    begin_program();
    emit(itype(op_addiu, 0, 1, 5));
    emit(itype(op_addiu, 0, 2, 5));
    emit(itype(op_addiu, 0, 3, 7));
    emit(itype(op_beq, 1, 2, 3));
    emit(itype(op_sw, 0, 1, data_base + 'h10));
    emit(itype(op_sw, 0, 2, data_base + 'h14));
    emit(itype(op_sw, 0, 3, data_base + 'h18));
    emit(itype(op_beq, 1, 3, 1));
    emit(itype(op_sw, 0, 3, data_base));
    emit(itype(op_addiu, 0, 5, 9));
    emit(itype(op_bne, 5, 1, 2));
    emit(itype(op_sw, 0, 1, data_base + 'h1c));
    emit(itype(op_sw, 0, 2, data_base + 'h20));
    emit(itype(op_bne, 1, 2, 1));
    emit(itype(op_sw, 0, 1, data_base + 4));
    emit(jword(pc_init + 18 * 4));
    emit(itype(op_sw, 0, 3, data_base + 'h24));
    emit(itype(op_sw, 0, 3, data_base + 'h28));
    emit(itype(op_addiu, 1, 4, 1));
    emit(itype(op_sw, 0, 4, data_base + 8));
    emit(halt_instr);

    // only the not-taken paths and the jump target store
    expect_store(data_base, 32'd7);
    expect_store(data_base + 4, 32'd5);
    expect_store(data_base + 8, 32'd6);
    run_program(first);
  endtask

  initial begin
    CLK          = 1'b0;
    rst_n        = 1'b0;
    ihit         = 1'b0;
    dhit         = 1'b0;
    imemload     = '0;
    dmemload     = '0;
    seed         = 32'h6cc802f2;
    errors       = 0;
    cycle_count  = 0;
    random_waits = 1'b0;
    iwait        = 0;
    dwait        = 0;
    dreq_prev    = 1'b0;
    pend_valid   = 1'b0;

    test_alu_chain();
    test_load_use();
    test_branches();

    random_waits = 1'b1;
    test_alu_chain();
    test_load_use();
    test_branches();

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: pipeline_cpu.f
cpu_types_pkg.sv
datapath_cache_if.sv
register_file.sv
alu.sv
control_unit.sv
forward_unit.sv
hazard_unit.sv
datapath.sv
pipeline_cpu.sv
pipeline_cpu_tb.sv
